// ==== include/sys_cfg.svh ====
`ifndef SYS_CFG_SVH
`define SYS_CFG_SVH

// Requester ports, two tiles and the host.
`define SYS_NUM_PORTS 3

// Cores reached by the wake-up register.
`define SYS_NUM_CORES 4

`define SYS_ADDR_WIDTH 32
`define SYS_DATA_WIDTH 32

// L2 word address width, 1024 words.
`define SYS_L2_ADDR_WIDTH 10

// Address map. Anything outside both windows goes to the external port.
`define SYS_CTRL_BASE 32'h4000_0000
`define SYS_CTRL_END  32'h4000_FFFF
`define SYS_L2_BASE   32'h8000_0000
`define SYS_L2_END    32'hBFFF_FFFF

`endif

// ==== source/sys_pkg.sv ====
`include "sys_cfg.svh"

package sys_pkg;

  typedef logic [`SYS_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`SYS_DATA_WIDTH-1:0]   data_t;
  typedef logic [`SYS_DATA_WIDTH/8-1:0] strb_t;

  // Targets on the shared bus.
  typedef enum logic [1:0] {
    CTRL_REGS,
    L2_MEMORY,
    EXTERNAL
  } target_e;

  // Control register offsets inside the 64 KiB window.
  localparam logic [15:0] REG_WAKE_UP   = 16'h0000;
  localparam logic [15:0] REG_EOC       = 16'h0004;
  localparam logic [15:0] REG_NUM_CORES = 16'h0008;

endpackage : sys_pkg

// ==== source/sys_bus_if.sv ====
`timescale 1ns/1ns

interface sys_bus_if;

  logic          req;
  logic          gnt;
  sys_pkg::addr_t addr;
  logic          we;
  sys_pkg::data_t wdata;
  sys_pkg::strb_t be;
  logic          rvalid;
  sys_pkg::data_t rdata;

  modport master (
    output req,
    output addr,
    output we,
    output wdata,
    output be,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport slave (
    input  req,
    input  addr,
    input  we,
    input  wdata,
    input  be,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface : sys_bus_if

// ==== source/sys_arbiter.sv ====
`timescale 1ns/1ns

`include "sys_cfg.svh"

module sys_arbiter (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic           [`SYS_NUM_PORTS-1:0]    req_i,
  input  sys_pkg::addr_t [`SYS_NUM_PORTS-1:0]    addr_i,
  input  logic           [`SYS_NUM_PORTS-1:0]    we_i,
  input  sys_pkg::data_t [`SYS_NUM_PORTS-1:0]    wdata_i,
  input  sys_pkg::strb_t [`SYS_NUM_PORTS-1:0]    be_i,
  output logic           [`SYS_NUM_PORTS-1:0]    gnt_o,
  output logic           [`SYS_NUM_PORTS-1:0]    rvalid_o,
  output sys_pkg::data_t [`SYS_NUM_PORTS-1:0]    rdata_o,
  sys_bus_if.master                              bus
);

  localparam int unsigned NumPorts = `SYS_NUM_PORTS;
  localparam int unsigned IdWidth  = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [IdWidth-1:0] rr_q;
  logic [IdWidth-1:0] sel;
  logic               found;
  logic               push;
  logic               pop;

  // Source IDs of granted transfers, in grant order.
  logic [IdWidth-1:0] id_fifo_q [2];
  logic               wr_ptr_q;
  logic               rd_ptr_q;
  logic [1:0]         id_cnt_q;
  logic [IdWidth-1:0] head_id;

  // First requester at or after the pointer.
  always_comb begin
    int unsigned idx;
    sel   = rr_q;
    found = 1'b0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      idx = int'(rr_q) + i;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!found && req_i[idx]) begin
        found = 1'b1;
        sel   = IdWidth'(idx);
      end
    end
  end

  assign bus.req   = found;
  assign bus.addr  = addr_i[sel];
  assign bus.we    = we_i[sel];
  assign bus.wdata = wdata_i[sel];
  assign bus.be    = be_i[sel];

  assign push = bus.req & bus.gnt;
  assign pop  = bus.rvalid;

  always_comb begin
    gnt_o      = '0;
    gnt_o[sel] = found & bus.gnt;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q     <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      id_cnt_q <= '0;
    end else begin
      if (push) begin
        rr_q <= (sel == IdWidth'(NumPorts - 1)) ? '0 : sel + 1'b1;
      end
      wr_ptr_q <= wr_ptr_q ^ push;
      rd_ptr_q <= rd_ptr_q ^ pop;
      id_cnt_q <= id_cnt_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_fifo_q[wr_ptr_q] <= sel;
    end
  end

  // Steer each response to the port at the head of the FIFO.
  assign head_id = id_fifo_q[rd_ptr_q];

  always_comb begin
    rvalid_o          = '0;
    rvalid_o[head_id] = bus.rvalid;
  end

  assign rdata_o = {NumPorts{bus.rdata}};

  id_fifo_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> id_cnt_q != 2'd2);

  rvalid_has_id: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.rvalid |-> id_cnt_q != 2'd0);

endmodule : sys_arbiter

// ==== source/sys_addr_decoder.sv ====
`timescale 1ns/1ns

`include "sys_cfg.svh"

module sys_addr_decoder (
  input  logic           clk_i,
  input  logic           rst_n_i,
  sys_bus_if.slave       up,
  sys_bus_if.master      l2,
  sys_bus_if.master      ctrl,
  output logic           ext_req_o,
  output sys_pkg::addr_t ext_addr_o,
  output logic           ext_we_o,
  output sys_pkg::data_t ext_wdata_o,
  output sys_pkg::strb_t ext_be_o,
  input  logic           ext_gnt_i,
  input  logic           ext_rvalid_i,
  input  sys_pkg::data_t ext_rdata_i,
  output logic           busy_o
);

  sys_pkg::target_e tgt;
  logic             ext_pend_q;
  logic             int_pend_q;
  logic             int_xfer;

  always_comb begin
    tgt = sys_pkg::EXTERNAL;
    if (up.addr >= `SYS_CTRL_BASE && up.addr <= `SYS_CTRL_END) begin
      tgt = sys_pkg::CTRL_REGS;
    end else if (up.addr >= `SYS_L2_BASE && up.addr <= `SYS_L2_END) begin
      tgt = sys_pkg::L2_MEMORY;
    end
  end

  // Nothing new goes out while the external port owes a response.
  assign l2.req    = up.req & (tgt == sys_pkg::L2_MEMORY) & ~ext_pend_q;
  assign ctrl.req  = up.req & (tgt == sys_pkg::CTRL_REGS) & ~ext_pend_q;
  assign ext_req_o = up.req & (tgt == sys_pkg::EXTERNAL) & ~ext_pend_q;

  assign l2.addr     = up.addr;
  assign l2.we       = up.we;
  assign l2.wdata    = up.wdata;
  assign l2.be       = up.be;
  assign ctrl.addr   = up.addr;
  assign ctrl.we     = up.we;
  assign ctrl.wdata  = up.wdata;
  assign ctrl.be     = up.be;
  assign ext_addr_o  = up.addr;
  assign ext_we_o    = up.we;
  assign ext_wdata_o = up.wdata;
  assign ext_be_o    = up.be;

  always_comb begin
    case (tgt)
      sys_pkg::L2_MEMORY: up.gnt = l2.gnt & ~ext_pend_q;
      sys_pkg::CTRL_REGS: up.gnt = ctrl.gnt & ~ext_pend_q;
      default:            up.gnt = ext_gnt_i & ~ext_pend_q;
    endcase
  end

  // The three response streams never overlap.
  assign up.rvalid = l2.rvalid | ctrl.rvalid | ext_rvalid_i;

  always_comb begin
    if (l2.rvalid) begin
      up.rdata = l2.rdata;
    end else if (ctrl.rvalid) begin
      up.rdata = ctrl.rdata;
    end else begin
      up.rdata = ext_rdata_i;
    end
  end

  assign int_xfer = (l2.req & l2.gnt) | (ctrl.req & ctrl.gnt);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ext_pend_q <= 1'b0;
      int_pend_q <= 1'b0;
    end else begin
      // Internal targets always answer in the next cycle.
      int_pend_q <= int_xfer;
      if (ext_req_o && ext_gnt_i) begin
        ext_pend_q <= 1'b1;
      end else if (ext_rvalid_i) begin
        ext_pend_q <= 1'b0;
      end
    end
  end

  assign busy_o = up.req | int_pend_q | ext_pend_q;

  resp_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({l2.rvalid, ctrl.rvalid, ext_rvalid_i}));

endmodule : sys_addr_decoder

// ==== source/l2_mem.sv ====
`timescale 1ns/1ns

`include "sys_cfg.svh"

module l2_mem (
  input  logic     clk_i,
  input  logic     rst_n_i,
  sys_bus_if.slave bus
);

  localparam int unsigned NumWords  = 2 ** `SYS_L2_ADDR_WIDTH;
  localparam int unsigned StrbWidth = $bits(sys_pkg::strb_t);

  sys_pkg::data_t                 mem_q [NumWords];
  sys_pkg::data_t                 rdata_q;
  logic                           rvalid_q;
  logic [`SYS_L2_ADDR_WIDTH-1:0] word_idx;
  logic                           xfer;

  assign word_idx = bus.addr[`SYS_L2_ADDR_WIDTH+1:2];
  assign xfer     = bus.req & bus.gnt;

  // Single port, never stalls.
  assign bus.gnt = 1'b1;

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      if (bus.we) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (bus.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= xfer;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule : l2_mem

// ==== source/ctrl_registers.sv ====
`timescale 1ns/1ns

`include "sys_cfg.svh"

module ctrl_registers (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  sys_bus_if.slave                  bus,
  output logic [`SYS_NUM_CORES-1:0] wake_up_o,
  output sys_pkg::data_t            eoc_o,
  output logic                      eoc_valid_o
);

  logic [15:0]               offset;
  logic                      xfer;
  logic                      wake_wr;
  logic                      eoc_wr;
  logic [`SYS_NUM_CORES-1:0] wake_up_q;
  sys_pkg::data_t            eoc_q;
  logic                      eoc_valid_q;
  sys_pkg::data_t            read_word;
  sys_pkg::data_t            rdata_q;
  logic                      rvalid_q;

  assign offset  = bus.addr[15:0];
  assign xfer    = bus.req & bus.gnt;
  assign wake_wr = xfer & bus.we & (offset == sys_pkg::REG_WAKE_UP);
  assign eoc_wr  = xfer & bus.we & (offset == sys_pkg::REG_EOC);

  assign bus.gnt = 1'b1;

  // Wake-up reads back as zero.
  always_comb begin
    case (offset)
      sys_pkg::REG_EOC:       read_word = eoc_q;
      sys_pkg::REG_NUM_CORES: read_word = sys_pkg::data_t'(`SYS_NUM_CORES);
      default:                read_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wake_up_q   <= '0;
      eoc_q       <= '0;
      eoc_valid_q <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      // One-cycle pulse per written core bit.
      wake_up_q <= wake_wr ? bus.wdata[`SYS_NUM_CORES-1:0] : '0;
      if (eoc_wr) begin
        eoc_q       <= bus.wdata;
        eoc_valid_q <= bus.wdata[0];
      end
      rvalid_q <= xfer;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rdata_q <= bus.we ? '0 : read_word;
    end
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_o       = eoc_q;
  assign eoc_valid_o = eoc_valid_q;

endmodule : ctrl_registers

// ==== source/mini_system.sv ====
`timescale 1ns/1ns

`include "sys_cfg.svh"

module mini_system (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Requester ports.
  input  logic           [`SYS_NUM_PORTS-1:0] port_req_i,
  input  sys_pkg::addr_t [`SYS_NUM_PORTS-1:0] port_addr_i,
  input  logic           [`SYS_NUM_PORTS-1:0] port_we_i,
  input  sys_pkg::data_t [`SYS_NUM_PORTS-1:0] port_wdata_i,
  input  sys_pkg::strb_t [`SYS_NUM_PORTS-1:0] port_be_i,
  output logic           [`SYS_NUM_PORTS-1:0] port_gnt_o,
  output logic           [`SYS_NUM_PORTS-1:0] port_rvalid_o,
  output sys_pkg::data_t [`SYS_NUM_PORTS-1:0] port_rdata_o,
  // External target.
  output logic                                ext_req_o,
  output sys_pkg::addr_t                      ext_addr_o,
  output logic                                ext_we_o,
  output sys_pkg::data_t                      ext_wdata_o,
  output sys_pkg::strb_t                      ext_be_o,
  input  logic                                ext_gnt_i,
  input  logic                                ext_rvalid_i,
  input  sys_pkg::data_t                      ext_rdata_i,
  // System status.
  output logic           [`SYS_NUM_CORES-1:0] wake_up_o,
  output sys_pkg::data_t                      eoc_o,
  output logic                                eoc_valid_o,
  output logic                                busy_o
);

  sys_bus_if arb_to_dec ();
  sys_bus_if dec_to_l2 ();
  sys_bus_if dec_to_ctrl ();

  sys_arbiter i_arbiter (
    .clk_i   (clk_i        ),
    .rst_n_i (rst_n_i      ),
    .req_i   (port_req_i   ),
    .addr_i  (port_addr_i  ),
    .we_i    (port_we_i    ),
    .wdata_i (port_wdata_i ),
    .be_i    (port_be_i    ),
    .gnt_o   (port_gnt_o   ),
    .rvalid_o(port_rvalid_o),
    .rdata_o (port_rdata_o ),
    .bus     (arb_to_dec   )
  );

  sys_addr_decoder i_addr_decoder (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .up          (arb_to_dec  ),
    .l2          (dec_to_l2   ),
    .ctrl        (dec_to_ctrl ),
    .ext_req_o   (ext_req_o   ),
    .ext_addr_o  (ext_addr_o  ),
    .ext_we_o    (ext_we_o    ),
    .ext_wdata_o (ext_wdata_o ),
    .ext_be_o    (ext_be_o    ),
    .ext_gnt_i   (ext_gnt_i   ),
    .ext_rvalid_i(ext_rvalid_i),
    .ext_rdata_i (ext_rdata_i ),
    .busy_o      (busy_o      )
  );

  l2_mem i_l2_mem (
    .clk_i  (clk_i    ),
    .rst_n_i(rst_n_i  ),
    .bus    (dec_to_l2)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .bus        (dec_to_ctrl),
    .wake_up_o  (wake_up_o  ),
    .eoc_o      (eoc_o      ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : mini_system

// ==== sim/tb_mini_system.sv ====
`timescale 1ns/1ns

`include "sys_cfg.svh"

module tb_mini_system;

  localparam int NumPorts   = `SYS_NUM_PORTS;
  localparam int NumEntries = 16;
  localparam int CycleLimit = 40 * NumEntries + 200;

  // A set group flag starts three entries that request together.
  typedef struct {
    int             port;
    logic           we;
    sys_pkg::addr_t addr;
    sys_pkg::data_t wdata;
    sys_pkg::strb_t be;
    sys_pkg::data_t exp;
    bit             group;
  } entry_t;

  logic                                clk_i;
  logic                                rst_n_i;
  logic           [NumPorts-1:0]       port_req_i;
  sys_pkg::addr_t [NumPorts-1:0]       port_addr_i;
  logic           [NumPorts-1:0]       port_we_i;
  sys_pkg::data_t [NumPorts-1:0]       port_wdata_i;
  sys_pkg::strb_t [NumPorts-1:0]       port_be_i;
  logic           [NumPorts-1:0]       port_gnt_o;
  logic           [NumPorts-1:0]       port_rvalid_o;
  sys_pkg::data_t [NumPorts-1:0]       port_rdata_o;
  logic                                ext_req_o;
  sys_pkg::addr_t                      ext_addr_o;
  logic                                ext_we_o;
  sys_pkg::data_t                      ext_wdata_o;
  sys_pkg::strb_t                      ext_be_o;
  logic                                ext_gnt_i;
  logic                                ext_rvalid_i;
  sys_pkg::data_t                      ext_rdata_i;
  logic           [`SYS_NUM_CORES-1:0] wake_up_o;
  sys_pkg::data_t                      eoc_o;
  logic                                eoc_valid_o;
  logic                                busy_o;

  entry_t         tbl [NumEntries];
  sys_pkg::data_t l2_ref [2 ** `SYS_L2_ADDR_WIDTH];
  logic [31:0]    lcg_state = 32'h69a0_df00;
  int             errors;
  bit             ext_outstanding;

  mini_system mini_system_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("[FAIL] t=%0t %s", $time, msg);
  endtask

  task automatic load_table();
    tbl[0]  = '{0, 1'b1, 32'h8000_0010, 32'h1122_3344, 4'hF, 32'h0, 1'b0};
    tbl[1]  = '{1, 1'b1, 32'h8000_0010, 32'hAABB_CCDD, 4'h5, 32'h0, 1'b0};
    tbl[2]  = '{2, 1'b0, 32'h8000_0010, 32'h0, 4'hF, 32'h0, 1'b0};
    tbl[3]  = '{1, 1'b1, 32'h8000_0FFC, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b0};
    tbl[4]  = '{0, 1'b1, 32'h8000_0FFC, 32'h0000_5500, 4'h2, 32'h0, 1'b0};
    tbl[5]  = '{2, 1'b0, 32'h8000_0FFC, 32'h0, 4'hF, 32'h0, 1'b0};
    tbl[6]  = '{2, 1'b1, 32'h4000_0004, 32'h0000_0001, 4'hF, 32'h0, 1'b0};
    tbl[7]  = '{0, 1'b0, 32'h4000_0004, 32'h0, 4'hF, 32'h0000_0001, 1'b0};
    tbl[8]  = '{1, 1'b0, 32'h4000_0008, 32'h0, 4'hF, 32'h0000_0004, 1'b0};
    tbl[9]  = '{0, 1'b1, 32'h4000_0000, 32'h0000_0005, 4'hF, 32'h0, 1'b0};
    tbl[10] = '{1, 1'b0, 32'h1234_5678, 32'h0, 4'hF, 32'h0, 1'b0};
    tbl[11] = '{2, 1'b1, 32'hC000_0000, 32'h0000_00FF, 4'hF, 32'h0, 1'b0};
    tbl[12] = '{0, 1'b0, 32'h8000_0010, 32'h0, 4'hF, 32'h0, 1'b1};
    tbl[13] = '{1, 1'b0, 32'h2000_0040, 32'h0, 4'hF, 32'h0, 1'b0};
    tbl[14] = '{2, 1'b1, 32'h8000_0020, 32'hCAFE_F00D, 4'hF, 32'h0, 1'b0};
    tbl[15] = '{1, 1'b0, 32'h8000_0020, 32'h0, 4'hF, 32'h0, 1'b0};
  endtask

  // Expected response data, taken at the grant. L2 writes update the reference.
  function automatic sys_pkg::data_t expected_at_grant(input int k);
    int unsigned    idx;
    sys_pkg::data_t word;
    idx  = tbl[k].addr[`SYS_L2_ADDR_WIDTH+1:2];
    word = l2_ref[idx];
    if (tbl[k].addr inside {[`SYS_L2_BASE:`SYS_L2_END]}) begin
      if (!tbl[k].we) return word;
      for (int b = 0; b < 4; b++) begin
        if (tbl[k].be[b]) word[8*b +: 8] = tbl[k].wdata[8*b +: 8];
      end
      l2_ref[idx] = word;
      return '0;
    end
    if (tbl[k].we) return '0;
    if (tbl[k].addr inside {[`SYS_CTRL_BASE:`SYS_CTRL_END]}) return tbl[k].exp;
    return tbl[k].addr ^ 32'h5A5A_5A5A;
  endfunction

  task automatic run_one(input int k);
    int             p;
    int             waited;
    bit             is_ext;
    sys_pkg::data_t exp;
    p      = tbl[k].port;
    is_ext = !(tbl[k].addr inside {[`SYS_CTRL_BASE:`SYS_CTRL_END], [`SYS_L2_BASE:`SYS_L2_END]});
    @(posedge clk_i);
    port_req_i[p]   <= 1'b1;
    port_addr_i[p]  <= tbl[k].addr;
    port_we_i[p]    <= tbl[k].we;
    port_wdata_i[p] <= tbl[k].wdata;
    port_be_i[p]    <= tbl[k].be;
    @(negedge clk_i);
    while (!port_gnt_o[p]) begin
      if (busy_o !== 1'b1) flag_error($sformatf("busy_o low while port %0d waits", p));
      @(negedge clk_i);
    end
    if (is_ext) begin
      if (ext_req_o !== 1'b1 || ext_addr_o !== tbl[k].addr || ext_we_o !== tbl[k].we ||
          ext_wdata_o !== tbl[k].wdata || ext_be_o !== tbl[k].be)
        flag_error($sformatf("entry %0d external request %b addr %h we %b wdata %h be %h",
                             k, ext_req_o, ext_addr_o, ext_we_o, ext_wdata_o, ext_be_o));
    end else if (ext_req_o !== 1'b0) begin
      flag_error($sformatf("entry %0d reached the external port", k));
    end
    exp = expected_at_grant(k);
    @(posedge clk_i);
    port_req_i[p] <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!port_rvalid_o[p]) begin
      if (busy_o !== 1'b1) flag_error($sformatf("entry %0d busy_o low before rvalid", k));
      waited++;
      @(negedge clk_i);
    end
    if (port_rdata_o[p] !== exp)
      flag_error($sformatf("entry %0d port %0d rdata %h, expected %h",
                           k, p, port_rdata_o[p], exp));
    if (!is_ext && waited != 0)
      flag_error($sformatf("entry %0d rvalid %0d cycles late", k, waited));
    if (busy_o !== 1'b1) flag_error($sformatf("entry %0d busy_o low at rvalid", k));
    if (tbl[k].we && tbl[k].addr == `SYS_CTRL_BASE + sys_pkg::REG_EOC) begin
      if (eoc_o !== tbl[k].wdata || eoc_valid_o !== tbl[k].wdata[0])
        flag_error($sformatf("eoc_o %h valid %b after write", eoc_o, eoc_valid_o));
    end
    if (tbl[k].we && tbl[k].addr == `SYS_CTRL_BASE + sys_pkg::REG_WAKE_UP) begin
      if (wake_up_o !== tbl[k].wdata[`SYS_NUM_CORES-1:0])
        flag_error($sformatf("wake_up_o %b after write", wake_up_o));
      @(negedge clk_i);
      if (wake_up_o !== '0) flag_error("wake_up_o held for more than one cycle");
    end
  endtask

  // External target with a random latency of 1 to 4 cycles.
  initial begin : ext_responder
    sys_pkg::addr_t cap_addr;
    logic           cap_we;
    int             delay;
    ext_gnt_i       = 1'b1;
    ext_rvalid_i    = 1'b0;
    ext_rdata_i     = '0;
    ext_outstanding = 1'b0;
    forever begin
      @(negedge clk_i);
      if (ext_req_o && ext_gnt_i) begin
        cap_addr = ext_addr_o;
        cap_we   = ext_we_o;
        delay    = 1 + int'(lcg_next() >> 16) % 4;
        @(posedge clk_i);
        ext_outstanding = 1'b1;
        repeat (delay - 1) @(posedge clk_i);
        ext_rvalid_i <= 1'b1;
        ext_rdata_i  <= cap_we ? '0 : cap_addr ^ 32'h5A5A_5A5A;
        @(posedge clk_i);
        ext_rvalid_i    <= 1'b0;
        ext_outstanding = 1'b0;
      end
    end
  end

  // Round-robin order and back-pressure.
  initial begin : grant_monitor
    int rr_ptr;
    int winner;
    int j;
    rr_ptr = 0;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && port_gnt_o != '0) begin
        winner = -1;
        for (int i = 0; i < NumPorts; i++) begin
          j = (rr_ptr + i) % NumPorts;
          if (winner < 0 && port_req_i[j]) winner = j;
        end
        if (winner < 0 || port_gnt_o != NumPorts'(1 << winner))
          flag_error($sformatf("grant %b, expected port %0d", port_gnt_o, winner));
        rr_ptr = (winner + 1) % NumPorts;
      end
      if (ext_outstanding && port_gnt_o != '0)
        flag_error($sformatf("grant %b during external transfer", port_gnt_o));
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", CycleLimit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    int k;
    rst_n_i      = 1'b0;
    port_req_i   = '0;
    port_addr_i  = '0;
    port_we_i    = '0;
    port_wdata_i = '0;
    port_be_i    = '0;
    errors       = 0;
    load_table();
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    if (busy_o !== 1'b0 || ext_req_o !== 1'b0 || eoc_valid_o !== 1'b0 || wake_up_o !== '0)
      flag_error("outputs not idle after reset");
    k = 0;
    while (k < NumEntries) begin
      if (tbl[k].group) begin
        fork
          run_one(k);
          run_one(k + 1);
          run_one(k + 2);
        join
        k += 3;
      end else begin
        run_one(k);
        k++;
      end
      @(negedge clk_i);
      if (busy_o !== 1'b0) flag_error("busy_o high while idle");
    end
    $display("Entries run: %0d, errors: %0d", NumEntries, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_mini_system

// ==== tb.f ====
+incdir+include
source/sys_pkg.sv
source/sys_bus_if.sv
source/sys_arbiter.sv
source/sys_addr_decoder.sv
source/l2_mem.sv
source/ctrl_registers.sv
source/mini_system.sv
sim/tb_mini_system.sv

// ==== Bender.yml ====
package:
  name: mini_system

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/sys_pkg.sv
      - source/sys_bus_if.sv
      - source/sys_arbiter.sv
      - source/sys_addr_decoder.sv
      - source/l2_mem.sv
      - source/ctrl_registers.sv
      - source/mini_system.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_mini_system.sv
